//--- bench/cache_tb.sv
/* testbench of the two-way data cache with a RAM model that stalls at random
   directed and random CPU accesses all checked against a reference model */
module cache_tb;

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int          WAIT_LIMIT = 100;
    localparam logic [31:0] LFSR_SEED  = 32'hadac0c79;

    logic    clk;
    logic    rst_i;
    logic    req_valid_i;
    logic    req_we_i;
    sel_t    req_sel_i;
    addr_t   req_addr_i;
    word_t   req_wdata_i;
    logic    req_ready_o;
    logic    resp_valid_o;
    word_t   resp_rdata_o;
    logic    ram_req_valid_o;
    ram_op_e ram_op_o;
    addr_t   ram_addr_o;
    word_t   ram_wdata_o;
    logic    ram_req_ready_i  = 1'b0;
    logic    ram_resp_valid_i = 1'b0;
    word_t   ram_rdata_i      = '0;

    // RAM model
    word_t       ram_mem [addr_t];
    logic [31:0] ram_lfsr = LFSR_SEED;
    int          stall_left;
    logic        resp_pending;
    int          resp_delay;
    addr_t       resp_addr;

    // reference model of shadow memory and cache contents
    word_t       shadow_mem [addr_t];
    tag_t        m_tag   [NUM_SETS][NUM_WAYS];
    logic        m_valid [NUM_SETS][NUM_WAYS];
    logic        m_dirty [NUM_SETS][NUM_WAYS];
    way_t        m_lru   [NUM_SETS];
    logic [31:0] stim_lfsr = LFSR_SEED;

    // expectations of the access in flight
    logic  exp_we;
    logic  exp_hit;
    logic  exp_wb;
    addr_t exp_addr;
    addr_t exp_wb_addr;
    word_t exp_wb_data;
    word_t exp_rdata;

    // owned by the comparing process
    int   cycle_cnt    = 0;
    int   accept_cycle = 0;
    int   ram_rd_cnt   = 0;
    int   ram_wr_cnt   = 0;
    logic outstanding  = 1'b0;
    int   cmp_mismatch = 0;
    int   cmp_other    = 0;

    // owned by the stimulus
    int   seq_mismatch = 0;
    int   seq_other    = 0;
    int   timeout_cnt  = 0;
    logic timed_out    = 1'b0;

    clk_gen u_clk_gen (
        .clk_o (clk)
    );

    cache_top u_cache_top (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_we_i         (req_we_i),
        .req_sel_i        (req_sel_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .ram_req_valid_o  (ram_req_valid_o),
        .ram_req_ready_i  (ram_req_ready_i),
        .ram_op_o         (ram_op_o),
        .ram_addr_o       (ram_addr_o),
        .ram_wdata_o      (ram_wdata_o),
        .ram_resp_valid_i (ram_resp_valid_i),
        .ram_rdata_i      (ram_rdata_i)
    );

    function automatic word_t ram_default(input addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic word_t ram_read(input addr_t a);
        return ram_mem.exists(a) ? ram_mem[a] : ram_default(a);
    endfunction

    function automatic word_t shadow_read(input addr_t a);
        return shadow_mem.exists(a) ? shadow_mem[a] : ram_default(a);
    endfunction

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            r     = {r[30:0], fb};
        end
        return r;
    endfunction

    // updates the model and sets exp_hit, exp_wb and the write-back word
    function automatic word_t ref_access(input logic we, input sel_t sel,
                                         input addr_t addr, input word_t wdata);
        addr_t  wa;
        index_t idx;
        tag_t   tag;
        way_t   way;
        word_t  cur;
        int     w;
        int     b;
        wa      = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        idx     = addr[OFFSET_W +: INDEX_W];
        tag     = addr[ADDR_W-1 -: TAG_W];
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        way     = m_lru[idx];
        for (w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && (m_tag[idx][w] == tag)) begin
                exp_hit = 1'b1;
                way     = way_t'(w);
            end
        end
        if (!exp_hit) begin
            // only a modified victim goes back to RAM
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb      = 1'b1;
                exp_wb_addr = {m_tag[idx][way], idx, {OFFSET_W{1'b0}}};
                exp_wb_data = shadow_read(exp_wb_addr);
            end
            m_tag[idx][way]   = tag;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
        end
        m_lru[idx] = ~way;
        if (we) begin
            cur = shadow_read(wa);
            for (b = 0; b < SEL_W; b++) begin
                if (sel[b]) begin
                    cur[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow_mem[wa]    = cur;
            m_dirty[idx][way] = 1'b1;
        end
        return shadow_read(wa);
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, want);
    endtask

    task automatic note_timeout(input string what);
        timeout_cnt++;
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // one CPU access that returns on the edge showing resp_valid_o
    task automatic do_access(input logic we, input sel_t sel, input addr_t addr,
                             input word_t wdata);
        int t;
        if (!timed_out) begin
            @(posedge clk);
            exp_we      = we;
            exp_addr    = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            exp_rdata   = ref_access(we, sel, addr, wdata);
            req_valid_i <= 1'b1;
            req_we_i    <= we;
            req_sel_i   <= sel;
            req_addr_i  <= addr;
            req_wdata_i <= wdata;
            t = 0;
            @(posedge clk);
            while (!req_ready_o && t < WAIT_LIMIT) begin
                @(posedge clk);
                t++;
            end
            req_valid_i <= 1'b0;
            if (!req_ready_o) begin
                note_timeout("request was never accepted");
            end else begin
                t = 0;
                @(posedge clk);
                while (!resp_valid_o && t < WAIT_LIMIT) begin
                    @(posedge clk);
                    t++;
                end
                if (!resp_valid_o) begin
                    note_timeout("no response to an accepted request");
                end
            end
        end
    endtask

    task automatic check_ram_traffic(input int reads, input int writes, input string what);
        assert (ram_rd_cnt == reads && ram_wr_cnt == writes) else begin
            seq_other++;
            $display("%s: expected %0d RAM reads and %0d RAM writes, saw %0d and %0d",
                     what, reads, writes, ram_rd_cnt, ram_wr_cnt);
        end
    endtask

    // RAM with 0 to 3 cycles of stall and of read latency
    always @(posedge clk) begin
        if (rst_i) begin
            ram_req_ready_i  <= 1'b0;
            ram_resp_valid_i <= 1'b0;
            stall_left   = 0;
            resp_pending = 1'b0;
            resp_delay   = 0;
            resp_addr    = '0;
        end else begin
            ram_resp_valid_i <= 1'b0;
            if (resp_pending) begin
                if (resp_delay == 0) begin
                    ram_resp_valid_i <= 1'b1;
                    ram_rdata_i      <= ram_read(resp_addr);
                    resp_pending = 1'b0;
                end else begin
                    resp_delay--;
                end
            end
            if (ram_req_valid_o && ram_req_ready_i) begin
                ram_req_ready_i <= 1'b0;
                stall_left = int'(take_bits(ram_lfsr, 2));
                if (ram_op_o == RAM_WRITE) begin
                    ram_mem[ram_addr_o] = ram_wdata_o;
                end else begin
                    resp_pending = 1'b1;
                    resp_delay   = int'(take_bits(ram_lfsr, 2));
                    resp_addr    = ram_addr_o;
                end
            end else if (ram_req_valid_o) begin
                if (stall_left == 0) begin
                    ram_req_ready_i <= 1'b1;
                end else begin
                    stall_left--;
                end
            end
        end
    end

    // compares every RAM transfer and every response with the expectations
    always @(posedge clk) begin
        if (rst_i) begin
            cycle_cnt   = 0;
            outstanding = 1'b0;
        end else begin
            cycle_cnt++;
            if (req_valid_i && req_ready_o) begin
                accept_cycle = cycle_cnt;
                ram_rd_cnt   = 0;
                ram_wr_cnt   = 0;
                outstanding  = 1'b1;
            end
            if (ram_req_valid_o && ram_req_ready_i) begin
                if (ram_op_o == RAM_WRITE) begin
                    ram_wr_cnt++;
                    assert (exp_wb) else begin
                        cmp_other++;
                        $display("RAM write to %h although no dirty victim was expected",
                                 ram_addr_o);
                    end
                    if (exp_wb) begin
                        assert (ram_addr_o == exp_wb_addr) else begin
                            cmp_mismatch++;
                            show_mismatch("ram_addr_o", ram_addr_o, exp_wb_addr);
                        end
                        assert (ram_wdata_o == exp_wb_data) else begin
                            cmp_mismatch++;
                            show_mismatch("ram_wdata_o", ram_wdata_o, exp_wb_data);
                        end
                    end
                end else begin
                    ram_rd_cnt++;
                    assert (!exp_hit) else begin
                        cmp_other++;
                        $display("RAM read of %h on an access that should hit", ram_addr_o);
                    end
                    assert (ram_addr_o == exp_addr) else begin
                        cmp_mismatch++;
                        show_mismatch("ram_addr_o", ram_addr_o, exp_addr);
                    end
                end
            end
            if (resp_valid_o) begin
                assert (outstanding) else begin
                    cmp_other++;
                    $display("response pulse with no request outstanding");
                end
                outstanding = 1'b0;
                assert (req_ready_o) else begin
                    cmp_other++;
                    $display("req_ready_o is low during the response pulse");
                end
                if (exp_hit) begin
                    assert (cycle_cnt - accept_cycle == 2) else begin
                        cmp_other++;
                        $display("hit response came %0d edges after acceptance",
                                 cycle_cnt - accept_cycle);
                    end
                end
                if (!exp_we) begin
                    assert (resp_rdata_o == exp_rdata) else begin
                        cmp_mismatch++;
                        show_mismatch("resp_rdata_o", resp_rdata_o, exp_rdata);
                    end
                end
                assert (ram_rd_cnt == (exp_hit ? 0 : 1)) else begin
                    cmp_other++;
                    $display("access to %h made %0d RAM reads", exp_addr, ram_rd_cnt);
                end
                assert (ram_wr_cnt == (exp_wb ? 1 : 0)) else begin
                    cmp_other++;
                    $display("access to %h made %0d RAM writes", exp_addr, ram_wr_cnt);
                end
            end
        end
    end

    initial begin
        addr_t       a;
        logic [31:0] r_we;
        logic [31:0] r_sel;
        logic [31:0] r_tag;
        logic [31:0] r_idx;
        logic [31:0] r_data;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_sel_i   = '0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        m_valid     = '{default: 1'b0};
        m_dirty     = '{default: 1'b0};
        m_lru       = '{default: 1'b0};
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);
        assert (req_ready_o && !resp_valid_o && !ram_req_valid_o) else begin
            seq_other++;
            $display("idle handshake outputs are wrong after reset");
        end

        // first read gives the RAM default and partial writes then merge
        do_access(1'b0, 4'hf, 32'h0000_0100, '0);
        do_access(1'b1, 4'b0011, 32'h0000_0100, 32'h1122_3344);
        do_access(1'b1, 4'b1000, 32'h0000_0102, 32'haabb_ccdd);
        do_access(1'b0, 4'hf, 32'h0000_0100, '0);
        check_ram_traffic(0, 0, "read hit");

        // dirty victim in set 1 goes back and clean victim does not
        do_access(1'b1, 4'hf, 32'h0000_1004, 32'hdead_beef);
        do_access(1'b0, 4'hf, 32'h0000_2004, '0);
        do_access(1'b0, 4'hf, 32'h0000_3004, '0);
        check_ram_traffic(1, 1, "dirty eviction");
        do_access(1'b0, 4'hf, 32'h0000_1004, '0);
        check_ram_traffic(1, 0, "clean eviction");

        // A B A C in set 2 keeps A and drops B
        do_access(1'b0, 4'hf, 32'h0000_1008, '0);
        do_access(1'b0, 4'hf, 32'h0000_2008, '0);
        do_access(1'b0, 4'hf, 32'h0000_1008, '0);
        do_access(1'b0, 4'hf, 32'h0000_3008, '0);
        do_access(1'b0, 4'hf, 32'h0000_1008, '0);
        check_ram_traffic(0, 0, "recently used line");
        do_access(1'b0, 4'hf, 32'h0000_2008, '0);
        check_ram_traffic(1, 0, "replaced line");

        // 16 addresses with four tags per set
        for (int n = 0; n < 300; n++) begin
            r_we   = take_bits(stim_lfsr, 1);
            r_sel  = take_bits(stim_lfsr, SEL_W);
            r_tag  = take_bits(stim_lfsr, 2);
            r_idx  = take_bits(stim_lfsr, INDEX_W);
            r_data = take_bits(stim_lfsr, DATA_W);
            a = 32'h0004_0000 | (r_tag << 12) | (r_idx << OFFSET_W);
            do_access(r_we[0], r_sel[SEL_W-1:0], a, r_data);
        end
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                a = 32'h0004_0000 | (t << 12) | (i << OFFSET_W);
                do_access(1'b0, 4'hf, a, '0);
            end
        end

        // two fresh tags per set push every dirty line out to RAM
        for (int i = 0; i < NUM_SETS; i++) begin
            do_access(1'b0, 4'hf, 32'h00f0_0000 | (i << OFFSET_W), '0);
            do_access(1'b0, 4'hf, 32'h00f1_0000 | (i << OFFSET_W), '0);
        end
        foreach (shadow_mem[k]) begin
            assert (ram_read(k) == shadow_mem[k]) else begin
                seq_mismatch++;
                show_mismatch($sformatf("ram_mem[%h]", k), ram_read(k), shadow_mem[k]);
            end
        end

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 cmp_mismatch + seq_mismatch, cmp_other + seq_other, timeout_cnt);
        if (cmp_mismatch + seq_mismatch + cmp_other + seq_other + timeout_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
/* free-running testbench clock with a period of 4 time units */
module clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

//--- hdl/cache_ctrl.sv
/* request register and FSM of the blocking cache that looks up, writes back a
   dirty victim over the RAM port, then refills and looks up again to hit */
module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  logic                    req_we_i,
    input  cache_geom_pkg::sel_t    req_sel_i,
    input  cache_geom_pkg::addr_t   req_addr_i,
    input  cache_geom_pkg::word_t   req_wdata_i,
    output logic                    resp_valid_o,
    output cache_geom_pkg::word_t   resp_rdata_o,
    output logic                    ram_req_valid_o,
    input  logic                    ram_req_ready_i,
    output cache_ctrl_pkg::ram_op_e ram_op_o,
    output cache_geom_pkg::addr_t   ram_addr_o,
    output cache_geom_pkg::word_t   ram_wdata_o,
    input  logic                    ram_resp_valid_i,
    input  cache_geom_pkg::word_t   ram_rdata_i,
    output cache_geom_pkg::index_t  index_o,
    output cache_geom_pkg::tag_t    tag_o,
    output logic                    wr_en_o,
    output cache_geom_pkg::sel_t    wr_sel_o,
    output cache_geom_pkg::word_t   wr_data_o,
    output logic                    fill_en_o,
    output cache_geom_pkg::word_t   fill_data_o,
    output cache_geom_pkg::way_t    fill_way_o,
    input  logic                    hit_i,
    input  cache_geom_pkg::way_t    hit_way_i,
    input  cache_geom_pkg::word_t   hit_data_i,
    input  logic                    victim_dirty_i,
    input  cache_geom_pkg::tag_t    victim_tag_i,
    input  cache_geom_pkg::word_t   victim_data_i,
    output logic                    touch_o,
    output cache_geom_pkg::way_t    touch_way_o,
    input  cache_geom_pkg::way_t    victim_way_i
);

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic   req_we_q;
    sel_t   req_sel_q;
    word_t  req_wdata_q;
    index_t req_index_q;
    tag_t   req_tag_q;
    logic   resp_valid_q;
    word_t  resp_rdata_q;
    logic   lookup_hit;

    assign req_ready_o = (state_q == ST_IDLE);
    assign lookup_hit  = (state_q == ST_LOOKUP) && hit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit_i) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = ST_EVICT;
                end else begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_EVICT: begin
                if (ram_req_ready_i) begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                if (ram_req_ready_i) begin
                    state_d = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                // refilled line is looked up again and hits
                if (ram_resp_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= lookup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_we_q    <= req_we_i;
            req_sel_q   <= req_sel_i;
            req_wdata_q <= req_wdata_i;
            req_index_q <= req_addr_i[OFFSET_W +: INDEX_W];
            req_tag_q   <= req_addr_i[ADDR_W-1 -: TAG_W];
        end
        if (lookup_hit) begin
            resp_rdata_q <= hit_data_i;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_rdata_o = resp_rdata_q;

    // line access for the registered request
    assign index_o     = req_index_q;
    assign tag_o       = req_tag_q;
    assign wr_en_o     = lookup_hit && req_we_q;
    assign wr_sel_o    = req_sel_q;
    assign wr_data_o   = req_wdata_q;
    assign touch_o     = lookup_hit;
    assign touch_way_o = hit_way_i;

    // nothing touches the set before the fill so the victim way holds still
    assign fill_en_o   = (state_q == ST_FILL_WAIT) && ram_resp_valid_i;
    assign fill_data_o = ram_rdata_i;
    assign fill_way_o  = victim_way_i;

    assign ram_req_valid_o = (state_q == ST_EVICT) || (state_q == ST_FILL_REQ);
    assign ram_op_o        = (state_q == ST_EVICT) ? RAM_WRITE : RAM_READ;
    assign ram_addr_o      = (state_q == ST_EVICT) ?
                             {victim_tag_i, req_index_q, {OFFSET_W{1'b0}}} :
                             {req_tag_q, req_index_q, {OFFSET_W{1'b0}}};
    assign ram_wdata_o     = victim_data_i;

endmodule

//--- hdl/cache_ctrl_pkg.sv
/* controller state and RAM request encodings shared by the cache
   controller, the top level and the testbench RAM model */
package cache_ctrl_pkg;

    // lookup, optional write-back of a dirty victim, then refill
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT,
        ST_FILL_REQ,
        ST_FILL_WAIT
    } ctrl_state_e;

    // kind of RAM transfer; only reads get a response
    typedef enum logic {
        RAM_READ,
        RAM_WRITE
    } ram_op_e;

endpackage

//--- hdl/cache_geom_pkg.sv
/* geometry of the data cache with address split, field widths and their types
   imported by every block that touches addresses, words or line fields */
package cache_geom_pkg;

    // byte-addressed 32-bit CPU port
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int SEL_W    = DATA_W / 8;
    localparam int OFFSET_W = 2;

    // four sets, two ways, one word per line
    localparam int NUM_SETS = 4;
    localparam int INDEX_W  = 2;
    localparam int NUM_WAYS = 2;

    // tag is everything above index and byte offset
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [SEL_W-1:0]   sel_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // names way 0 or way 1
    typedef logic way_t;

endpackage

//--- hdl/cache_lru.sv
/* one replacement bit per set, naming the way to evict next
   a touch points the bit at the other way */
module cache_lru (
    input  logic                   clk,
    input  logic                   rst_i,
    input  cache_geom_pkg::index_t index_i,
    input  logic                   touch_i,
    input  cache_geom_pkg::way_t   touch_way_i,
    output cache_geom_pkg::way_t   victim_way_o
);

    import cache_geom_pkg::*;

    way_t lru_q [NUM_SETS];

    assign victim_way_o = lru_q[index_i];

    // all sets start out pointing at way 0
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lru_q <= '{default: 1'b0};
        end else if (touch_i) begin
            lru_q[index_i] <= ~touch_way_i;
        end
    end

endmodule

//--- hdl/cache_top.sv
/* two-way write-back data cache between a CPU data port and a slower RAM
   CPU and RAM requests use valid/ready and the CPU response is a one-cycle pulse */
module cache_top (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  logic                    req_we_i,
    input  cache_geom_pkg::sel_t    req_sel_i,
    input  cache_geom_pkg::addr_t   req_addr_i,
    input  cache_geom_pkg::word_t   req_wdata_i,
    output logic                    resp_valid_o,
    output cache_geom_pkg::word_t   resp_rdata_o,
    output logic                    ram_req_valid_o,
    input  logic                    ram_req_ready_i,
    output cache_ctrl_pkg::ram_op_e ram_op_o,
    output cache_geom_pkg::addr_t   ram_addr_o,
    output cache_geom_pkg::word_t   ram_wdata_o,
    input  logic                    ram_resp_valid_i,
    input  cache_geom_pkg::word_t   ram_rdata_i
);

    import cache_geom_pkg::*;

    index_t index;
    tag_t   tag;
    logic   wr_en;
    sel_t   wr_sel;
    word_t  wr_data;
    logic   fill_en;
    word_t  fill_data;
    way_t   fill_way;
    logic   hit;
    way_t   hit_way;
    word_t  hit_data;
    logic   victim_dirty;
    tag_t   victim_tag;
    word_t  victim_data;
    logic   touch;
    way_t   touch_way;
    way_t   victim_way;

    cache_ctrl u_ctrl (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_we_i         (req_we_i),
        .req_sel_i        (req_sel_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .ram_req_valid_o  (ram_req_valid_o),
        .ram_req_ready_i  (ram_req_ready_i),
        .ram_op_o         (ram_op_o),
        .ram_addr_o       (ram_addr_o),
        .ram_wdata_o      (ram_wdata_o),
        .ram_resp_valid_i (ram_resp_valid_i),
        .ram_rdata_i      (ram_rdata_i),
        .index_o          (index),
        .tag_o            (tag),
        .wr_en_o          (wr_en),
        .wr_sel_o         (wr_sel),
        .wr_data_o        (wr_data),
        .fill_en_o        (fill_en),
        .fill_data_o      (fill_data),
        .fill_way_o       (fill_way),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .hit_data_i       (hit_data),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .victim_data_i    (victim_data),
        .touch_o          (touch),
        .touch_way_o      (touch_way),
        .victim_way_i     (victim_way)
    );

    // write hits go to the way that matched
    cache_ways u_ways (
        .clk            (clk),
        .rst_i          (rst_i),
        .index_i        (index),
        .tag_i          (tag),
        .victim_way_i   (victim_way),
        .wr_en_i        (wr_en),
        .wr_way_i       (hit_way),
        .wr_sel_i       (wr_sel),
        .wr_data_i      (wr_data),
        .fill_en_i      (fill_en),
        .fill_way_i     (fill_way),
        .fill_data_i    (fill_data),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .hit_data_o     (hit_data),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_data_o  (victim_data)
    );

    cache_lru u_lru (
        .clk          (clk),
        .rst_i        (rst_i),
        .index_i      (index),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

endmodule

//--- hdl/cache_ways.sv
/* line storage with valid, dirty, tag and data for both ways of every set
   combinational hit and victim lookup, byte-merge write and refill on the clock */
module cache_ways (
    input  logic                   clk,
    input  logic                   rst_i,
    input  cache_geom_pkg::index_t index_i,
    input  cache_geom_pkg::tag_t   tag_i,
    input  cache_geom_pkg::way_t   victim_way_i,
    input  logic                   wr_en_i,
    input  cache_geom_pkg::way_t   wr_way_i,
    input  cache_geom_pkg::sel_t   wr_sel_i,
    input  cache_geom_pkg::word_t  wr_data_i,
    input  logic                   fill_en_i,
    input  cache_geom_pkg::way_t   fill_way_i,
    input  cache_geom_pkg::word_t  fill_data_i,
    output logic                   hit_o,
    output cache_geom_pkg::way_t   hit_way_o,
    output cache_geom_pkg::word_t  hit_data_o,
    output logic                   victim_dirty_o,
    output cache_geom_pkg::tag_t   victim_tag_o,
    output cache_geom_pkg::word_t  victim_data_o
);

    import cache_geom_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    word_t               data_q  [NUM_SETS][NUM_WAYS];

    word_t cur_word;
    word_t merged_word;

    // tag compare across both ways of the addressed set
    always_comb begin
        hit_o      = 1'b0;
        hit_way_o  = 1'b0;
        hit_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[index_i][w] && (tag_q[index_i][w] == tag_i)) begin
                hit_o      = 1'b1;
                hit_way_o  = way_t'(w);
                hit_data_o = data_q[index_i][w];
            end
        end
    end

    // a clean or empty victim needs no write-back
    assign victim_dirty_o = valid_q[index_i][victim_way_i] && dirty_q[index_i][victim_way_i];
    assign victim_tag_o   = tag_q[index_i][victim_way_i];
    assign victim_data_o  = data_q[index_i][victim_way_i];

    // byte lanes not selected keep the cached value
    assign cur_word = data_q[index_i][wr_way_i];

    always_comb begin
        for (int b = 0; b < SEL_W; b++) begin
            merged_word[8*b +: 8] = wr_sel_i[b] ? wr_data_i[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else if (fill_en_i) begin
            valid_q[index_i][fill_way_i] <= 1'b1;
            dirty_q[index_i][fill_way_i] <= 1'b0;
        end else if (wr_en_i) begin
            dirty_q[index_i][wr_way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[index_i][fill_way_i]  <= tag_i;
            data_q[index_i][fill_way_i] <= fill_data_i;
        end else if (wr_en_i) begin
            data_q[index_i][wr_way_i] <= merged_word;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module cache_tb -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cache_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** PASSED ***" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- sources.f
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_ways.sv
hdl/cache_lru.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
bench/clk_gen.sv
bench/cache_tb.sv
